/* verilog/i3c_bus_pkg.sv */
/*
  Shared types and constants for the I3C target bus front end.
  Holds the bus event codes carried from the monitor through the event
  FIFO to the address receiver, the receiver states and the widths.
  Modules reference these by scoped names.
*/

package i3c_bus_pkg;

  // Width of one encoded bus event
  localparam int unsigned EventWidth = 3;

  // Target address width, without the RnW bit
  localparam int unsigned AddrWidth = 7;

  // Hold window counter width, same as the controller timing fields
  localparam int unsigned FilterWidth = 20;

  // Address every I3C target answers to
  localparam logic [AddrWidth-1:0] BroadcastAddr = 7'h7E;

  // Conditions and data bits seen on the filtered bus
  typedef enum logic [EventWidth-1:0] {
    EV_START  = 3'd0,
    EV_RSTART = 3'd1,
    EV_STOP   = 3'd2,
    EV_BIT0   = 3'd3,
    EV_BIT1   = 3'd4
  } bus_event_e;

  // Address receiver states
  typedef enum logic [1:0] {
    // No transfer in progress
    RX_IDLE = 2'd0,
    // Shifting in the address byte
    RX_ADDR = 2'd1,
    // Byte done, bits are ignored until the next start or stop
    RX_SKIP = 2'd2
  } rx_state_e;

endpackage

/* verilog/bus_monitor.sv */
/*
  Bus monitor for the I3C target front end.
  Synchronizes SCL and SDA, filters glitches shorter than the hold
  window and turns the edges of the filtered lines into START, RSTART,
  STOP and data bit events, one registered strobe per event.
*/

module bus_monitor #(
  parameter int unsigned SyncStages = 2
) (
  input  logic clk_i,
  input  logic reset_i,

  input  logic scl_i,
  input  logic sda_i,
  input  logic [i3c_bus_pkg::FilterWidth-1:0] t_hd_dat_i,

  output logic event_valid_o,
  output i3c_bus_pkg::bus_event_e event_code_o
);

  localparam int unsigned NumLines = 2;
  localparam int unsigned Scl = 0;
  localparam int unsigned Sda = 1;

  logic [NumLines-1:0] line_raw;
  logic [SyncStages-1:0] sync_q [NumLines];
  logic [i3c_bus_pkg::FilterWidth-1:0] stable_cnt_q [NumLines];
  logic [NumLines-1:0] filt_q;
  logic [NumLines-1:0] filt_prev_q;
  logic bus_busy_q;

  logic scl_rise;
  logic scl_held_high;
  logic sda_fall;
  logic sda_rise;

  assign line_raw = {sda_i, scl_i};

  // Synchronizer chain and stability counter, one per line
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int l = 0; l < NumLines; l++) begin
        sync_q[l]       <= '1;
        stable_cnt_q[l] <= '0;
      end
      filt_q      <= '1;
      filt_prev_q <= '1;
    end else begin
      for (int l = 0; l < NumLines; l++) begin
        for (int s = SyncStages - 1; s > 0; s--) begin
          sync_q[l][s] <= sync_q[l][s-1];
        end
        sync_q[l][0] <= line_raw[l];

        // New level is taken after t_hd_dat_i+1 steady samples
        if (sync_q[l][SyncStages-1] != filt_q[l]) begin
          if (stable_cnt_q[l] == t_hd_dat_i) begin
            filt_q[l]       <= sync_q[l][SyncStages-1];
            stable_cnt_q[l] <= '0;
          end else begin
            stable_cnt_q[l] <= stable_cnt_q[l] + 1'b1;
          end
        end else begin
          stable_cnt_q[l] <= '0;
        end
      end
      filt_prev_q <= filt_q;
    end
  end

  assign scl_rise      = filt_q[Scl] & ~filt_prev_q[Scl];
  assign scl_held_high = filt_q[Scl] & filt_prev_q[Scl];
  assign sda_fall      = ~filt_q[Sda] & filt_prev_q[Sda];
  assign sda_rise      = filt_q[Sda] & ~filt_prev_q[Sda];

  // Bus busy flag
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bus_busy_q <= 1'b0;
    end else if (scl_held_high && sda_fall) begin
      bus_busy_q <= 1'b1;
    end else if (scl_held_high && sda_rise) begin
      bus_busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      event_valid_o <= 1'b0;
    end else begin
      event_valid_o <= 1'b0;
      if (scl_held_high && sda_fall) begin
        event_valid_o <= 1'b1;
      end else if (scl_held_high && sda_rise) begin
        event_valid_o <= 1'b1;
      end else if (scl_rise && bus_busy_q) begin
        event_valid_o <= 1'b1;
      end
    end
  end

  // Event code only matters while event_valid_o is high
  always_ff @(posedge clk_i) begin
    if (scl_held_high && sda_fall) begin
      event_code_o <= bus_busy_q ? i3c_bus_pkg::EV_RSTART : i3c_bus_pkg::EV_START;
    end else if (scl_held_high && sda_rise) begin
      event_code_o <= i3c_bus_pkg::EV_STOP;
    end else if (scl_rise) begin
      // Data is sampled on the rising SCL edge
      event_code_o <= filt_q[Sda] ? i3c_bus_pkg::EV_BIT1 : i3c_bus_pkg::EV_BIT0;
    end
  end

endmodule

/* verilog/bus_event_fifo.sv */
/*
  Show-ahead FIFO for bus events.
  The oldest event is always visible on head_event_o; pop_i drops it.
  A push into a full FIFO is lost and raises overflow_o until reset.
*/

module bus_event_fifo #(
  parameter int unsigned EventFifoDepth = 8
) (
  input  logic clk_i,
  input  logic reset_i,

  input  logic push_i,
  input  i3c_bus_pkg::bus_event_e push_event_i,
  input  logic pop_i,

  output i3c_bus_pkg::bus_event_e head_event_o,
  output logic empty_o,
  output logic overflow_o
);

  localparam int unsigned PtrWidth = (EventFifoDepth > 1) ? $clog2(EventFifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(EventFifoDepth + 1);

  logic [i3c_bus_pkg::EventWidth-1:0] mem [EventFifoDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;

  logic full;
  logic do_push;
  logic do_pop;

  assign full    = (count_q == CntWidth'(EventFifoDepth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty_o;

  assign head_event_o = i3c_bus_pkg::bus_event_e'(mem[rd_ptr_q]);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_event_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(EventFifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(EventFifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
      if (push_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

endmodule

/* verilog/addr_receiver.sv */
/*
  Address receiver for the I3C target front end.
  Pops bus events while enabled, reports START, RSTART and STOP as
  pulses and collects the address byte after each start, MSB first.
  Flags a hit on the static or the broadcast address until STOP.
*/

module addr_receiver (
  input  logic clk_i,
  input  logic reset_i,

  input  logic fsm_en_i,
  input  logic fifo_empty_i,
  input  i3c_bus_pkg::bus_event_e head_event_i,
  input  logic [i3c_bus_pkg::AddrWidth-1:0] target_sta_addr_i,

  output logic pop_o,
  output logic bus_start_o,
  output logic bus_rstart_o,
  output logic bus_stop_o,
  output logic [7:0] bus_addr_o,
  output logic bus_addr_valid_o,
  output logic addr_match_o,
  output logic fsm_idle_o
);

  i3c_bus_pkg::rx_state_e state_q;
  logic [2:0] bit_cnt_q;
  logic [i3c_bus_pkg::AddrWidth-1:0] shift_q;
  logic rx_bit;
  logic addr_hit;

  assign pop_o = fsm_en_i & ~fifo_empty_i;

  assign rx_bit = (head_event_i == i3c_bus_pkg::EV_BIT1);

  // Upper seven bits of the finished byte are the shifted bits
  assign addr_hit = (shift_q == target_sta_addr_i) || (shift_q == i3c_bus_pkg::BroadcastAddr);

  assign fsm_idle_o = (state_q == i3c_bus_pkg::RX_IDLE) && fifo_empty_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q          <= i3c_bus_pkg::RX_IDLE;
      bit_cnt_q        <= '0;
      bus_start_o      <= 1'b0;
      bus_rstart_o     <= 1'b0;
      bus_stop_o       <= 1'b0;
      bus_addr_valid_o <= 1'b0;
      addr_match_o     <= 1'b0;
    end else begin
      bus_start_o      <= 1'b0;
      bus_rstart_o     <= 1'b0;
      bus_stop_o       <= 1'b0;
      bus_addr_valid_o <= 1'b0;
      if (pop_o) begin
        case (head_event_i)
          i3c_bus_pkg::EV_START: begin
            bus_start_o <= 1'b1;
            state_q     <= i3c_bus_pkg::RX_ADDR;
            bit_cnt_q   <= '0;
          end
          i3c_bus_pkg::EV_RSTART: begin
            bus_rstart_o <= 1'b1;
            state_q      <= i3c_bus_pkg::RX_ADDR;
            bit_cnt_q    <= '0;
          end
          i3c_bus_pkg::EV_STOP: begin
            bus_stop_o   <= 1'b1;
            addr_match_o <= 1'b0;
            state_q      <= i3c_bus_pkg::RX_IDLE;
          end
          default: begin
            if (state_q == i3c_bus_pkg::RX_ADDR) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              // Eighth bit is RnW and completes the byte
              if (bit_cnt_q == 3'd7) begin
                bus_addr_valid_o <= 1'b1;
                state_q          <= i3c_bus_pkg::RX_SKIP;
                if (addr_hit) begin
                  addr_match_o <= 1'b1;
                end
              end
            end
          end
        endcase
      end
    end
  end

  // Address shift register and the reported byte
  always_ff @(posedge clk_i) begin
    if (pop_o && state_q == i3c_bus_pkg::RX_ADDR && bit_cnt_q != 3'd7 &&
        (head_event_i == i3c_bus_pkg::EV_BIT0 || head_event_i == i3c_bus_pkg::EV_BIT1)) begin
      shift_q <= {shift_q[i3c_bus_pkg::AddrWidth-2:0], rx_bit};
    end
    if (pop_o && state_q == i3c_bus_pkg::RX_ADDR && bit_cnt_q == 3'd7 &&
        (head_event_i == i3c_bus_pkg::EV_BIT0 || head_event_i == i3c_bus_pkg::EV_BIT1)) begin
      bus_addr_o <= {shift_q, rx_bit};
    end
  end

endmodule

/* verilog/i3c_target_frontend.sv */
/*
  Bus-facing front end of an I3C target.
  Chains the bus monitor, the event FIFO and the address receiver.
  Events queue in the FIFO while i3c_fsm_en_i is low.
*/

module i3c_target_frontend #(
  parameter int unsigned EventFifoDepth = 8,
  parameter int unsigned SyncStages     = 2
) (
  input  logic clk_i,
  input  logic reset_i,

  input  logic scl_i,
  input  logic sda_i,
  input  logic [i3c_bus_pkg::FilterWidth-1:0] t_hd_dat_i,
  input  logic [i3c_bus_pkg::AddrWidth-1:0] target_sta_addr_i,
  input  logic i3c_fsm_en_i,

  output logic bus_start_o,
  output logic bus_rstart_o,
  output logic bus_stop_o,
  output logic [7:0] bus_addr_o,
  output logic bus_addr_valid_o,
  output logic addr_match_o,
  output logic i3c_fsm_idle_o,
  output logic err_o
);

  logic event_valid;
  i3c_bus_pkg::bus_event_e event_code;
  logic fifo_empty;
  i3c_bus_pkg::bus_event_e head_event;
  logic pop;

  bus_monitor #(
    .SyncStages (SyncStages)
  ) xbus_monitor (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .scl_i         (scl_i),
    .sda_i         (sda_i),
    .t_hd_dat_i    (t_hd_dat_i),
    .event_valid_o (event_valid),
    .event_code_o  (event_code)
  );

  bus_event_fifo #(
    .EventFifoDepth (EventFifoDepth)
  ) xbus_event_fifo (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_i       (event_valid),
    .push_event_i (event_code),
    .pop_i        (pop),
    .head_event_o (head_event),
    .empty_o      (fifo_empty),
    .overflow_o   (err_o)
  );

  addr_receiver xaddr_receiver (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .fsm_en_i          (i3c_fsm_en_i),
    .fifo_empty_i      (fifo_empty),
    .head_event_i      (head_event),
    .target_sta_addr_i (target_sta_addr_i),
    .pop_o             (pop),
    .bus_start_o       (bus_start_o),
    .bus_rstart_o      (bus_rstart_o),
    .bus_stop_o        (bus_stop_o),
    .bus_addr_o        (bus_addr_o),
    .bus_addr_valid_o  (bus_addr_valid_o),
    .addr_match_o      (addr_match_o),
    .fsm_idle_o        (i3c_fsm_idle_o)
  );

endmodule

/* test/tb_i3c_target_frontend.sv */
/*
  Testbench for the I3C target front end.
  Reads bus operations and expected values from test/i3c_testdata.txt,
  drives SCL and SDA waveforms into the DUT and checks pulses and flags.
*/

module tb_i3c_target_frontend;

  timeunit 1ns;
  timeprecision 100ps;

  // Deeper than the default so one whole transfer fits while disabled
  localparam int unsigned FifoDepth = 16;
  localparam int unsigned Stages = 2;
  localparam logic [i3c_bus_pkg::FilterWidth-1:0] HoldWindow = 3;
  localparam int unsigned Window = HoldWindow + 1;
  localparam int unsigned MaxPhase = 6 * Window;
  localparam logic [i3c_bus_pkg::AddrWidth-1:0] StaticAddr = 7'h2A;
  // Monitor latency, FIFO and receiver stages, then a full FIFO of pops
  localparam int unsigned DrainCycles = Stages + HoldWindow + 2 + 2 + FifoDepth;

  logic clk;
  logic reset;
  logic scl;
  logic sda;
  logic [i3c_bus_pkg::FilterWidth-1:0] t_hd_dat;
  logic [i3c_bus_pkg::AddrWidth-1:0] target_sta_addr;
  logic fsm_en;
  logic bus_start;
  logic bus_rstart;
  logic bus_stop;
  logic [7:0] bus_addr;
  logic bus_addr_valid;
  logic addr_match;
  logic fsm_idle;
  logic err;

  integer seed = 32'h73a6;
  int unsigned start_cnt;
  int unsigned rstart_cnt;
  int unsigned stop_cnt;
  int unsigned addr_cnt;
  logic [7:0] last_addr;
  logic last_match;
  int unsigned errors;
  int unsigned test_errors;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned checks;
  bit settle_needed;
  longint unsigned watchdog_ns;

  logic [7:0] op_q[$];
  int unsigned arg_a_q[$];
  int unsigned arg_b_q[$];
  int unsigned arg_c_q[$];

  i3c_target_frontend #(
    .EventFifoDepth (FifoDepth),
    .SyncStages     (Stages)
  ) dut (
    .clk_i             (clk),
    .reset_i           (reset),
    .scl_i             (scl),
    .sda_i             (sda),
    .t_hd_dat_i        (t_hd_dat),
    .target_sta_addr_i (target_sta_addr),
    .i3c_fsm_en_i      (fsm_en),
    .bus_start_o       (bus_start),
    .bus_rstart_o      (bus_rstart),
    .bus_stop_o        (bus_stop),
    .bus_addr_o        (bus_addr),
    .bus_addr_valid_o  (bus_addr_valid),
    .addr_match_o      (addr_match),
    .i3c_fsm_idle_o    (fsm_idle),
    .err_o             (err)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Pulse counters, outputs are registered and stable at the edge
  always @(posedge clk) begin
    if (!reset) begin
      if (bus_start) start_cnt++;
      if (bus_rstart) rstart_cnt++;
      if (bus_stop) stop_cnt++;
      if (bus_addr_valid) begin
        addr_cnt++;
        last_addr = bus_addr;
      end
      last_match = addr_match;
    end
  end

  initial begin
    wait (watchdog_ns != 0);
    #(watchdog_ns);
    $display("Run timed out after %0d ns before the test sequence finished", watchdog_ns);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, actual,
               expected);
      errors++;
      test_errors++;
    end
  endtask

  // One bus phase of 4 to 6 filter windows
  task automatic bus_phase(input logic scl_lvl, input logic sda_lvl);
    int unsigned cycles;
    cycles = 4 * Window + ($unsigned($random(seed)) % (2 * Window + 1));
    scl = scl_lvl;
    sda = sda_lvl;
    settle_needed = 1'b1;
    repeat (cycles) @(posedge clk);
    #1;
  endtask

  task automatic drive_start();
    bus_phase(1'b1, 1'b0);
    bus_phase(1'b0, 1'b0);
  endtask

  task automatic drive_rstart();
    bus_phase(1'b0, 1'b1);
    bus_phase(1'b1, 1'b1);
    bus_phase(1'b1, 1'b0);
    bus_phase(1'b0, 1'b0);
  endtask

  task automatic drive_stop();
    bus_phase(1'b0, 1'b0);
    bus_phase(1'b1, 1'b0);
    bus_phase(1'b1, 1'b1);
  endtask

  // MSB first, then a ninth clock with SDA released
  task automatic send_byte(input logic [7:0] data);
    logic [8:0] bits;
    bits = {data, 1'b1};
    for (int i = 8; i >= 0; i--) begin
      bus_phase(1'b0, bits[i]);
      bus_phase(1'b1, bits[i]);
      bus_phase(1'b0, bits[i]);
    end
  endtask

  task automatic drive_glitch(input int unsigned cycles);
    sda = ~sda;
    repeat (cycles) @(posedge clk);
    #1;
    sda = ~sda;
    bus_phase(scl, sda);
  endtask

  task automatic wait_drain();
    if (settle_needed) begin
      repeat (DrainCycles) @(posedge clk);
      #1;
      settle_needed = 1'b0;
    end
  endtask

  task automatic expect_values(input int unsigned kind, input int unsigned a,
                               input int unsigned b);
    wait_drain();
    case (kind)
      0: begin
        check_value("bus_start_o count", start_cnt, a);
        check_value("bus_stop_o count", stop_cnt, b);
      end
      1: begin
        check_value("bus_rstart_o count", rstart_cnt, a);
        check_value("bus_addr_valid_o count", addr_cnt, b);
      end
      2: begin
        check_value("bus_addr_o", {24'h0, last_addr}, a);
        check_value("addr_match_o", {31'h0, last_match}, b);
      end
      3: begin
        check_value("i3c_fsm_idle_o", {31'h0, fsm_idle}, a);
        check_value("err_o", {31'h0, err}, b);
      end
      default: begin
        $display("Data file asks for unknown expect kind %0d", kind);
        errors++;
        test_errors++;
      end
    endcase
  endtask

  function automatic string test_name(input int unsigned num);
    case (num)
      1: return "start, byte, stop";
      2: return "address match";
      3: return "repeated start";
      4: return "SDA glitch filter";
      5: return "disabled consumer";
      6: return "event FIFO overflow";
      default: return "unnamed";
    endcase
  endfunction

  task automatic end_test(input int unsigned num);
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %0d (%s) passed", num, test_name(num));
    end else begin
      $display("Test %0d (%s) failed with %0d errors", num, test_name(num), test_errors);
      tests_failed++;
    end
    test_errors = 0;
    start_cnt = 0;
    rstart_cnt = 0;
    stop_cnt = 0;
    addr_cnt = 0;
  endtask

  function automatic int unsigned phase_count(input logic [7:0] op);
    case (op)
      "S": return 2;
      "R": return 4;
      "P": return 3;
      "B": return 27;
      "G", "X": return 2;
      default: return 0;
    endcase
  endfunction

  task automatic read_testdata();
    int fd;
    string line;
    logic [7:0] op;
    int unsigned a;
    int unsigned b;
    int unsigned c;
    fd = $fopen("test/i3c_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the data file test/i3c_testdata.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      op = 8'h00;
      void'($fgets(line, fd));
      void'($sscanf(line, "%c %h %h %h", op, a, b, c));
      // Lines that do not start with an opcode letter are comments
      if (op >= "A" && op <= "Z") begin
        op_q.push_back(op);
        arg_a_q.push_back(a);
        arg_b_q.push_back(b);
        arg_c_q.push_back(c);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    int unsigned total;
    reset = 1'b1;
    scl = 1'b1;
    sda = 1'b1;
    fsm_en = 1'b1;
    t_hd_dat = HoldWindow;
    target_sta_addr = StaticAddr;
    read_testdata();
    if (op_q.size() == 0) begin
      $display("The data file holds no operations");
      errors++;
    end
    total = 1;
    foreach (op_q[i]) total += phase_count(op_q[i]);
    watchdog_ns = longint'(total) * MaxPhase * 2 * 8;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (op_q[i]) begin
      case (op_q[i])
        "S": drive_start();
        "R": drive_rstart();
        "P": drive_stop();
        "B": send_byte(8'(arg_a_q[i]));
        "G": drive_glitch(arg_a_q[i]);
        "X": expect_values(arg_a_q[i], arg_b_q[i], arg_c_q[i]);
        "T": end_test(arg_a_q[i]);
        "E": begin
          fsm_en = (arg_a_q[i] != 0);
          settle_needed = 1'b1;
        end
        default: begin
          $display("Data file holds unknown opcode %c", op_q[i]);
          errors++;
        end
      endcase
    end
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors", tests_run,
             tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* test/i3c_testdata.txt */
# op a: S start, R repeated start, P stop, B byte, E enable, G glitch cycles, T test id
# X kind a b (hex): 0 start/stop counts, 1 rstart/valid counts, 2 byte/match, 3 idle/err
E 1
S
B a5
P
X 0 1 1
X 1 0 1
X 2 a5 0
X 3 1 0
T 1
S
B 54
X 2 54 1
P
S
B fd
X 2 fd 1
P
S
B 67
X 2 67 0
P
X 0 3 3
T 2
S
B 54
R
B 5b
X 2 5b 1
P
X 0 1 1
X 1 1 2
T 3
G 3
G 2
X 0 0 0
X 1 0 0
X 3 1 0
T 4
E 0
S
B a5
P
X 0 0 0
X 1 0 0
X 3 0 0
E 1
X 0 1 1
X 1 0 1
X 2 a5 0
X 3 1 0
T 5
E 0
S
B 54
P
S
B 67
P
X 3 0 1
E 1
X 0 2 1
X 1 0 1
X 2 54 0
X 3 0 1
T 6

/* build.f */
verilog/i3c_bus_pkg.sv
verilog/bus_monitor.sv
verilog/bus_event_fifo.sv
verilog/addr_receiver.sv
verilog/i3c_target_frontend.sv
test/tb_i3c_target_frontend.sv

/* run_sim.sh */
#!/bin/sh
# Builds the I3C target front end testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -Wno-fatal -f build.f \
  --top-module tb_i3c_target_frontend -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log \
  || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
